// ==== hdl/soc_cfg.svh ====
/*
 * board and build settings for the memory and I/O side of the soc
 * clock, uart baud rate, ram geometry and flash boot block
 */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// system clock, from the burst ram controller clock output
`define CLK_FREQUENCY_HZ 30_000_000
`define UART_BAUD_RATE 3_000_000 // fast build, 10 clocks per bit

// byte address width of the burst ram
`define RAM_ADDRESS_BITWIDTH 21

// flash boot
`define STARTUP_WAIT_CYCLES 20
`define FLASH_TRANSFER_FROM_ADDRESS 24'h000100
`define FLASH_TRANSFER_BYTE_COUNT 16

`define UART_CLOCKS_PER_BIT (`CLK_FREQUENCY_HZ / `UART_BAUD_RATE)

`endif

// ==== hdl/soc_pkg.sv ====
/*
 * shared types for the soc: widths, access types, fsm states,
 * ramio request/response and burst ram port structs, io address map
 */
`include "soc_cfg.svh"

package soc_pkg;

  typedef logic [31:0] word_t;      // data or address word
  typedef logic [63:0] line_t;      // one burst ram beat
  typedef logic [7:0]  line_mask_t; // 1 = keep byte
  typedef logic [`RAM_ADDRESS_BITWIDTH-1:0] ram_addr_t;

  typedef logic [2:0] read_type_t;  // bit 2 set for unsigned
  typedef logic [1:0] write_type_t;

  // access sizes, low two bits of read/write type
  localparam logic [1:0] SZ_NONE = 2'd0;
  localparam logic [1:0] SZ_BYTE = 2'd1;
  localparam logic [1:0] SZ_HALF = 2'd2;
  localparam logic [1:0] SZ_WORD = 2'd3;

  // io address map, everything else with top bits clear is ram
  localparam word_t LED_ADDR      = 32'hFFFF_FFFF;
  localparam word_t UART_OUT_ADDR = 32'hFFFF_FFFE;
  localparam word_t UART_IN_ADDR  = 32'hFFFF_FFFD;

  typedef struct packed {
    logic        enable;     // one cycle, only when not busy
    read_type_t  read_type;
    write_type_t write_type;
    word_t       address;
    word_t       data_in;
  } ramio_req_t;

  typedef struct packed {
    word_t data_out;
    logic  data_out_ready;   // load done pulse
    logic  busy;
  } ramio_rsp_t;

  typedef struct packed {
    logic       cmd;         // 0 read, 1 write
    logic       cmd_en;
    ram_addr_t  addr;
    line_t      wr_data;
    line_mask_t data_mask;
  } br_req_t;

  typedef struct packed {
    line_t rd_data;
    logic  rd_data_valid;
  } br_rsp_t;

  typedef enum logic [2:0] {
    BOOT_WAIT, BOOT_CMD, BOOT_SHIFT, BOOT_STORE, BOOT_STORE_WAIT, BOOT_DONE
  } boot_state_t;

  typedef enum logic [1:0] {
    RIO_IDLE, RIO_RAM_READ, RIO_RAM_WRITE, RIO_UART_WAIT
  } ramio_state_t;

endpackage

// ==== hdl/uart_tx.sv ====
/*
 * uart transmitter, 8n1, lsb first
 * busy from start until the end of the stop bit
 */
`include "soc_cfg.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] data,
  output logic       tx,
  output logic       busy
);

  logic [8:0]  frame;  // stop bit + data, shifted out
  logic [3:0]  bit_idx;
  logic [15:0] clk_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      tx      <= 1'b1;   // line idles high
      busy    <= 1'b0;
      bit_idx <= '0;
      clk_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        frame   <= {1'b1, data};
        tx      <= 1'b0;  // start bit
        busy    <= 1'b1;
        bit_idx <= '0;
        clk_cnt <= '0;
      end
    end else if (clk_cnt == 16'(`UART_CLOCKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;     // stop bit done
      end else begin
        tx      <= frame[0];
        frame   <= {1'b1, frame[8:1]};
        bit_idx <= bit_idx + 1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1;
    end
  end

endmodule

// ==== hdl/uart_rx.sv ====
/*
 * uart receiver, 8n1
 * two flop sync, mid-bit sampling, valid pulse at the stop bit,
 * frames with a low stop bit are dropped
 */
`include "soc_cfg.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic       valid,
  output logic [7:0] data
);

  logic [1:0]  rx_sync;
  logic        rx_s;     // synchronized line
  logic        active;   // inside a frame
  logic [3:0]  bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [15:0] clk_cnt;  // counts down to the next mid-bit

  assign rx_s = rx_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_sync <= 2'b11;
      active  <= 1'b0;
      valid   <= 1'b0;
      bit_idx <= '0;
      clk_cnt <= '0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      valid   <= 1'b0;
      if (!active) begin
        if (!rx_s) begin                   // start edge
          active  <= 1'b1;
          bit_idx <= '0;
          clk_cnt <= 16'(`UART_CLOCKS_PER_BIT / 2 - 1);
        end
      end else if (clk_cnt == '0) begin
        clk_cnt <= 16'(`UART_CLOCKS_PER_BIT - 1);
        if (bit_idx == 4'd0) begin
          if (rx_s) active <= 1'b0;       // glitch, not a start bit
          else bit_idx <= 4'd1;
        end else if (bit_idx == 4'd9) begin
          active <= 1'b0;
          valid  <= rx_s;                  // bad stop bit, no valid
        end else begin
          bit_idx <= bit_idx + 1;
        end
      end else begin
        clk_cnt <= clk_cnt - 1;
      end
    end
  end

  // data bits, lsb first
  always_ff @(posedge clk) begin
    if (active && clk_cnt == '0 && bit_idx != 4'd0 && bit_idx != 4'd9)
      data <= {rx_s, data[7:1]};
  end

endmodule

// ==== hdl/ramio.sv ====
/*
 * memory and io unit
 * byte/half/word loads and stores to burst ram, one 64 bit beat per
 * access, plus the led register and the uart transmit/receive ports
 */
`include "soc_cfg.svh"

module ramio import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ramio_req_t req,
  output ramio_rsp_t rsp,
  output br_req_t    br_req,
  input  br_rsp_t    br_rsp,
  output logic       tx_start,
  output logic [7:0] tx_data,
  input  logic       tx_busy,
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  output logic [3:0] led
);

  // ------------------------------------------------------------------------
  // lane helpers
  // ------------------------------------------------------------------------

  // 1 marks a byte that must not be written
  function automatic line_mask_t lane_mask(write_type_t wt, logic [2:0] lane);
    line_mask_t sel;
    case (wt)
      SZ_BYTE: sel = 8'b0000_0001;
      SZ_HALF: sel = 8'b0000_0011;
      SZ_WORD: sel = 8'b0000_1111;
      default: sel = 8'b0000_0000;
    endcase
    return ~(sel << lane);
  endfunction

  // replicate so every lane carries the data
  function automatic line_t lane_data(write_type_t wt, word_t d);
    case (wt)
      SZ_BYTE: return {8{d[7:0]}};
      SZ_HALF: return {4{d[15:0]}};
      default: return {2{d}};
    endcase
  endfunction

  // pick lane, then sign or zero extend
  function automatic word_t lane_load(line_t beat, logic [2:0] lane, read_type_t rt);
    line_t sh;
    sh = beat >> {lane, 3'b000};
    case (rt[1:0])
      SZ_BYTE: return rt[2] ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
      SZ_HALF: return rt[2] ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
      default: return sh[31:0];
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------------

  ramio_state_t state;
  logic         is_ram, is_led, is_tx, is_rx;
  logic         is_load, is_store;
  logic [1:0]   acc_size;
  logic [1:0]   misalign;
  logic         cmd_en_q, cmd_q, rdy_q;
  ram_addr_t    addr_q;
  line_t        wr_data_q;
  line_mask_t   mask_q;
  word_t        data_out_q;
  word_t        io_rd;        // io load value
  logic [2:0]   lane_q;
  read_type_t   rtype_q;
  logic         rx_full;      // one entry receive buffer
  logic [7:0]   rx_buf;

  assign is_ram   = (req.address[31:`RAM_ADDRESS_BITWIDTH] == '0);
  assign is_led   = (req.address == LED_ADDR);
  assign is_tx    = (req.address == UART_OUT_ADDR);
  assign is_rx    = (req.address == UART_IN_ADDR);
  assign is_load  = (req.read_type[1:0] != SZ_NONE);
  assign is_store = (req.write_type != SZ_NONE);

  always_comb begin
    io_rd = '0;
    if (is_led) io_rd = {28'b0, led};
    else if (is_rx && rx_full) io_rd = {24'b0, rx_buf}; // empty reads 0
  end

  // ------------------------------------------------------------------------
  // access fsm
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RIO_IDLE;
      cmd_en_q <= 1'b0;
      rdy_q    <= 1'b0;
      tx_start <= 1'b0;
      led      <= '0;
      rx_full  <= 1'b0;
    end else begin
      cmd_en_q <= 1'b0;  // all strobes one cycle
      rdy_q    <= 1'b0;
      tx_start <= 1'b0;
      if (rx_valid) rx_full <= 1'b1;
      case (state)
        RIO_IDLE: begin
          if (req.enable) begin
            if (is_ram) begin
              cmd_en_q <= 1'b1;
              state    <= is_store ? RIO_RAM_WRITE : RIO_RAM_READ;
            end else if (is_load) begin
              rdy_q <= 1'b1;                       // io load, one cycle
              if (is_rx && !rx_valid) rx_full <= 1'b0;
            end else if (is_led) begin
              led <= req.data_in[3:0];
            end else if (is_tx) begin
              // tx_start counts as busy, uart_tx raises busy a cycle late
              if (tx_busy || tx_start) state <= RIO_UART_WAIT;
              else tx_start <= 1'b1;
            end
          end
        end
        RIO_RAM_WRITE: state <= RIO_IDLE;          // beat issued
        RIO_RAM_READ: begin
          if (br_rsp.rd_data_valid) begin
            rdy_q <= 1'b1;
            state <= RIO_IDLE;
          end
        end
        RIO_UART_WAIT: begin
          if (!tx_busy && !tx_start) begin
            tx_start <= 1'b1;
            state    <= RIO_IDLE;
          end
        end
        default: state <= RIO_IDLE;
      endcase
    end
  end

  // request payload, taken when the access is accepted
  always_ff @(posedge clk) begin
    if (state == RIO_IDLE && req.enable) begin
      cmd_q      <= is_store;
      addr_q     <= {req.address[`RAM_ADDRESS_BITWIDTH-1:3], 3'b000}; // beat aligned
      wr_data_q  <= lane_data(req.write_type, req.data_in);
      mask_q     <= lane_mask(req.write_type, req.address[2:0]);
      lane_q     <= req.address[2:0];
      rtype_q    <= req.read_type;
      tx_data    <= req.data_in[7:0];
      data_out_q <= io_rd;
    end else if (state == RIO_RAM_READ && br_rsp.rd_data_valid) begin
      data_out_q <= lane_load(br_rsp.rd_data, lane_q, rtype_q);
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) rx_buf <= rx_data;
  end

  assign br_req = '{cmd: cmd_q, cmd_en: cmd_en_q, addr: addr_q,
                    wr_data: wr_data_q, data_mask: mask_q};
  assign rsp = '{data_out: data_out_q, data_out_ready: rdy_q,
                 busy: (state != RIO_IDLE)};

  // master side protocol
  assign acc_size = is_store ? req.write_type : req.read_type[1:0];
  assign misalign = (acc_size == SZ_WORD) ? req.address[1:0] :
                    (acc_size == SZ_HALF) ? {1'b0, req.address[0]} : 2'b00;

  a_enable_idle: assert property (@(posedge clk) disable iff (rst)
    req.enable |-> !rsp.busy);

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    req.enable |-> misalign == 2'b00);

endmodule

// ==== hdl/flash_boot.sv ====
/*
 * flash boot loader
 * after a startup wait, reads a block from spi flash (cmd 03h) and
 * stores it byte by byte into ram, then hands the ram port to the host
 */
`include "soc_cfg.svh"

module flash_boot import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ramio_req_t host_req,
  output ramio_rsp_t host_rsp,
  output ramio_req_t ram_req,
  input  ramio_rsp_t ram_rsp,
  output logic       flash_cs_n,
  output logic       flash_clk,
  output logic       flash_mosi,
  input  logic       flash_miso,
  output logic       boot_done
);

  boot_state_t state;
  word_t       wait_cnt;  // startup delay
  word_t       byte_idx;  // also the ram address of the byte
  logic [31:0] cmd_sr;    // command + address, msb first
  logic [4:0]  bit_cnt;
  logic [7:0]  rx_byte;
  logic        sclk;
  ramio_req_t  boot_req;

  assign flash_clk  = sclk;       // clk/2 while shifting
  assign flash_mosi = cmd_sr[31];
  assign boot_done  = (state == BOOT_DONE);

  // ------------------------------------------------------------------------
  // boot fsm
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= BOOT_WAIT;
      wait_cnt   <= '0;
      byte_idx   <= '0;
      bit_cnt    <= '0;
      cmd_sr     <= '0;
      sclk       <= 1'b0;
      flash_cs_n <= 1'b1;
    end else begin
      case (state)
        BOOT_WAIT: begin
          if (wait_cnt == `STARTUP_WAIT_CYCLES - 1) begin
            flash_cs_n <= 1'b0;
            cmd_sr     <= {8'h03, `FLASH_TRANSFER_FROM_ADDRESS}; // read cmd
            bit_cnt    <= '0;
            state      <= BOOT_CMD;
          end else begin
            wait_cnt <= wait_cnt + 1;
          end
        end
        BOOT_CMD: begin
          sclk <= ~sclk;
          if (sclk) begin                   // falling edge, next mosi bit
            cmd_sr  <= {cmd_sr[30:0], 1'b0};
            bit_cnt <= bit_cnt + 1;
            if (bit_cnt == 5'd31) state <= BOOT_SHIFT;
          end
        end
        BOOT_SHIFT: begin
          sclk <= ~sclk;
          if (sclk) begin                   // miso taken in the high phase
            bit_cnt <= bit_cnt + 1;
            if (bit_cnt == 5'd7) state <= BOOT_STORE;
          end
        end
        BOOT_STORE: state <= BOOT_STORE_WAIT; // enable for this one cycle
        BOOT_STORE_WAIT: begin
          // flash clock stays low until ramio is free again
          if (!ram_rsp.busy) begin
            bit_cnt <= '0;
            if (byte_idx == `FLASH_TRANSFER_BYTE_COUNT - 1) begin
              flash_cs_n <= 1'b1;
              state      <= BOOT_DONE;
            end else begin
              byte_idx <= byte_idx + 1;
              state    <= BOOT_SHIFT;
            end
          end
        end
        BOOT_DONE: state <= BOOT_DONE;
        default:   state <= BOOT_WAIT;
      endcase
    end
  end

  // data byte from flash, msb first
  always_ff @(posedge clk) begin
    if (state == BOOT_SHIFT && sclk) rx_byte <= {rx_byte[6:0], flash_miso};
  end

  // ------------------------------------------------------------------------
  // ram port mux
  // ------------------------------------------------------------------------

  assign boot_req = '{enable:     (state == BOOT_STORE),
                      read_type:  '0,
                      write_type: SZ_BYTE,
                      address:    byte_idx,
                      data_in:    {24'b0, rx_byte}};

  always_comb begin
    if (boot_done) begin
      ram_req  = host_req;  // straight through after boot
      host_rsp = ram_rsp;
    end else begin
      ram_req  = boot_req;
      host_rsp = '{data_out: '0, data_out_ready: 1'b0, busy: 1'b1};
    end
  end

  // during boot a store only leaves with a whole flash byte shifted in
  a_boot_store_whole: assert property (@(posedge clk) disable iff (rst)
    !boot_done && ram_req.enable |-> bit_cnt == 5'd8);

endmodule

// ==== hdl/soc_top.sv ====
/*
 * soc top level, memory and io side
 * flash boot in front of ramio, uart pair and board leds
 */
module soc_top import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // external master, stands in for the core
  input  ramio_req_t host_req,
  output ramio_rsp_t host_rsp,
  // burst ram command port
  output br_req_t    br_req,
  input  br_rsp_t    br_rsp,
  // spi flash
  output logic       flash_cs_n,
  output logic       flash_clk,
  output logic       flash_mosi,
  input  logic       flash_miso,
  // serial
  input  logic       uart_rx,
  output logic       uart_tx,
  output logic [5:0] led
);

  ramio_req_t ram_req;  // boot or host, muxed in flash_boot
  ramio_rsp_t ram_rsp;
  logic       boot_done;
  logic       tx_start;
  logic [7:0] tx_data;
  logic       tx_busy;
  logic       rx_valid;
  logic [7:0] rx_data;

  // ------------------------------------------------------------------------
  // boot loader and memory unit
  // ------------------------------------------------------------------------

  flash_boot i_flash_boot (
    .clk, .rst,
    .host_req, .host_rsp,
    .ram_req, .ram_rsp,
    .flash_cs_n, .flash_clk, .flash_mosi, .flash_miso,
    .boot_done
  );

  ramio i_ramio (
    .clk, .rst,
    .req     (ram_req),
    .rsp     (ram_rsp),
    .br_req, .br_rsp,
    .tx_start, .tx_data, .tx_busy,
    .rx_valid, .rx_data,
    .led     (led[4:1])    // led register
  );

  // ------------------------------------------------------------------------
  // uart
  // ------------------------------------------------------------------------

  uart_tx i_uart_tx (
    .clk, .rst,
    .start (tx_start),
    .data  (tx_data),
    .tx    (uart_tx),
    .busy  (tx_busy)
  );

  uart_rx i_uart_rx (
    .clk, .rst,
    .rx    (uart_rx),
    .valid (rx_valid),
    .data  (rx_data)
  );

  assign led[0] = boot_done;
  assign led[5] = ~ram_rsp.busy; // lit while memory unit idle

endmodule

// ==== sim/tb_clk.sv ====
/*
 * testbench clock and reset
 * 4 ns clock, synchronous reset held for the first 5 cycles
 */
module tb_clk (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;            // released on a rising edge
  end

endmodule

// ==== sim/tb_models.sv ====
/*
 * behavioural models around the dut
 * spi flash answering read command 03h, and a 64 bit burst ram
 * with byte mask and a varying read latency
 */

// flash byte at address a is a[7:0] ^ a5h
module spi_flash_model (
  input  logic cs_n,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] cmd_sr;    // command byte + 24 bit address
  int unsigned rise_cnt;  // command bits taken in
  int unsigned out_cnt;   // data bits put out

  function automatic logic flash_bit(logic [23:0] base, int unsigned n);
    logic [23:0] a;
    logic [7:0]  b;
    a = base + 24'(n / 8);
    b = a[7:0] ^ 8'hA5;
    return b[7 - n % 8];    // msb first
  endfunction

  initial begin
    cmd_sr   = '0;
    rise_cnt = 0;
    out_cnt  = 0;
    miso     = 1'b0;
  end

  // new transfer on every deselect
  always @(posedge cs_n) begin
    rise_cnt = 0;
    out_cnt  = 0;
  end

  always @(posedge sclk) begin
    if (!cs_n && rise_cnt < 32) begin
      cmd_sr   = {cmd_sr[30:0], mosi};
      rise_cnt = rise_cnt + 1;
    end
  end

  // data shifts out on the falling edge
  always @(negedge sclk) begin
    if (!cs_n && rise_cnt == 32 && cmd_sr[31:24] == 8'h03) begin
      miso    <= flash_bit(cmd_sr[23:0], out_cnt);
      out_cnt  = out_cnt + 1;
    end
  end

endmodule

module burst_ram_model import soc_pkg::*; (
  input  logic    clk,
  input  br_req_t req,
  output br_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED = 32'h78ce_a24c;

  line_t       mem [int unsigned];  // beat index -> data
  int unsigned lat_cnt;             // 0 when no read pending
  int unsigned rd_idx;

  // never written beats read a pattern of the beat index
  function automatic line_t read_beat(int unsigned idx);
    if (mem.exists(idx)) return mem[idx];
    return {idx ^ 32'hC0DE_0000, ~idx};
  endfunction

  task automatic write_beat(int unsigned idx, line_t d, line_mask_t skip);
    line_t cur;
    int    b;
    cur = read_beat(idx);
    for (b = 0; b < 8; b++) begin
      if (!skip[b]) cur[8*b +: 8] = d[8*b +: 8];  // mask bit 1 leaves byte alone
    end
    mem[idx] = cur;
  endtask

  initial begin
    void'($urandom(SEED));
    lat_cnt = 0;
    rd_idx  = 0;
    rsp     = '0;
    forever begin
      @(posedge clk);
      rsp.rd_data_valid <= 1'b0;
      if (lat_cnt != 0) begin
        lat_cnt = lat_cnt - 1;
        if (lat_cnt == 0) begin
          rsp.rd_data       <= read_beat(rd_idx);
          rsp.rd_data_valid <= 1'b1;
        end
      end
      if (req.cmd_en) begin
        if (req.cmd) begin
          write_beat(32'(req.addr >> 3), req.wr_data, req.data_mask);
        end else begin
          rd_idx  = 32'(req.addr >> 3);
          lat_cnt = 2 + $urandom % 5;  // 2..6 cycles
        end
      end
    end
  end

endmodule

// ==== sim/tb_soc.sv ====
/*
 * testbench for soc_top
 * boot copy from spi flash, load sizes, byte masking, uart out/in, leds
 */
`include "soc_cfg.svh"

module tb_soc import soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // boot ~500 cycles, two uart frames ~200, ram accesses ~300, wide margin
  localparam int unsigned TIMEOUT_CYCLES = 20000;
  localparam int unsigned CPB = `UART_CLOCKS_PER_BIT;

  localparam read_type_t RD_SB = {1'b0, SZ_BYTE};  // bit 2 = zero extend
  localparam read_type_t RD_UB = {1'b1, SZ_BYTE};
  localparam read_type_t RD_SH = {1'b0, SZ_HALF};
  localparam read_type_t RD_UH = {1'b1, SZ_HALF};
  localparam read_type_t RD_W  = {1'b0, SZ_WORD};

  logic       clk;
  logic       rst;
  ramio_req_t host_req;
  ramio_rsp_t host_rsp;
  br_req_t    br_req;
  br_rsp_t    br_rsp;
  logic       flash_cs_n;
  logic       flash_clk;
  logic       flash_mosi;
  logic       flash_miso;
  logic       uart_rx;
  logic       uart_tx;
  logic [5:0] led;

  int unsigned err_cnt    = 0;
  int unsigned check_cnt  = 0;
  int unsigned test_cnt   = 0;
  int unsigned fail_tests = 0;
  int unsigned cycle_cnt  = 0;
  logic [7:0]  ref_bytes [0:7];  // expected bytes of 48h..4Fh

  tb_clk i_tb_clk (.clk, .rst);

  spi_flash_model i_flash (.cs_n(flash_cs_n), .sclk(flash_clk),
                           .mosi(flash_mosi), .miso(flash_miso));

  burst_ram_model i_ram (.clk, .req(br_req), .rsp(br_rsp));

  soc_top i_soc_top (
    .clk, .rst,
    .host_req, .host_rsp,
    .br_req, .br_rsp,
    .flash_cs_n, .flash_clk, .flash_mosi, .flash_miso,
    .uart_rx, .uart_tx,
    .led
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %-12s ok", name);
    end else begin
      fail_tests++;
      $display("test %-12s %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // one request, waits for data_out_ready on loads, busy low on stores
  task automatic host_access(input read_type_t rt, input write_type_t wt,
                             input word_t addr, input word_t wdata, output word_t rdata);
    @(posedge clk);
    while (host_rsp.busy) @(posedge clk);
    host_req <= '{enable: 1'b1, read_type: rt, write_type: wt,
                  address: addr, data_in: wdata};
    @(posedge clk);
    host_req <= '0;
    rdata = '0;
    if (rt[1:0] != SZ_NONE) begin
      do @(posedge clk); while (!host_rsp.data_out_ready);
      rdata = host_rsp.data_out;  // valid with the ready pulse
    end else begin
      do @(posedge clk); while (host_rsp.busy);
    end
  endtask

  task automatic host_store(input write_type_t wt, input word_t addr, input word_t data);
    word_t unused;
    host_access('0, wt, addr, data, unused);
  endtask

  task automatic host_load_check(input read_type_t rt, input word_t addr,
                                 input word_t exp, input string name);
    word_t got;
    host_access(rt, SZ_NONE, addr, '0, got);
    check_value(name, got, exp);
  endtask

  // store and update the little endian byte reference
  task automatic track_store(input write_type_t wt, input word_t addr, input word_t data);
    int n;
    int k;
    n = (wt == SZ_WORD) ? 4 : wt;
    for (k = 0; k < n; k++) ref_bytes[int'(addr[2:0]) + k] = data[8*k +: 8];
    host_store(wt, addr, data);
  endtask

  task automatic uart_send(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (CPB - 1) @(posedge clk);
    end
    @(posedge clk);
  endtask

  // samples uart_tx at mid-bit
  task automatic uart_receive(output logic [7:0] b);
    int i;
    do @(posedge clk); while (uart_tx !== 1'b0);
    repeat ((CPB - 1) / 2) @(posedge clk);
    check_value("uart_tx start bit", 32'(uart_tx), 32'd0);
    for (i = 0; i < 8; i++) begin
      repeat (CPB) @(posedge clk);
      b[i] = uart_tx;
    end
    repeat (CPB) @(posedge clk);
    check_value("uart_tx stop bit", 32'(uart_tx), 32'd1);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic test_boot_copy();
    int unsigned errs;
    int unsigned i;
    logic [23:0] a;
    errs = err_cnt;
    do begin
      @(posedge clk);
      if (led[0] !== 1'b1) check_value("host_rsp.busy", 32'(host_rsp.busy), 32'd1);
    end while (led[0] !== 1'b1);
    for (i = 0; i < `FLASH_TRANSFER_BYTE_COUNT; i++) begin
      a = `FLASH_TRANSFER_FROM_ADDRESS + i;
      host_load_check(RD_UB, i, {24'b0, a[7:0] ^ 8'hA5}, $sformatf("ram[%0d]", i));
    end
    report_test("boot_copy", errs);
  endtask

  task automatic test_load_sizes();
    int unsigned errs;
    errs = err_cnt;
    host_store(SZ_WORD, 32'h40, 32'h8000_80F1);  // bytes f1 80 00 80
    host_load_check(RD_SB, 32'h40, 32'hFFFF_FFF1, "lb 40");
    host_load_check(RD_UB, 32'h40, 32'h0000_00F1, "lbu 40");
    host_load_check(RD_SB, 32'h42, 32'h0000_0000, "lb 42");
    host_load_check(RD_UB, 32'h42, 32'h0000_0000, "lbu 42");
    host_load_check(RD_SB, 32'h43, 32'hFFFF_FF80, "lb 43");
    host_load_check(RD_SH, 32'h40, 32'hFFFF_80F1, "lh 40");
    host_load_check(RD_UH, 32'h40, 32'h0000_80F1, "lhu 40");
    host_load_check(RD_SH, 32'h42, 32'hFFFF_8000, "lh 42");
    host_load_check(RD_UH, 32'h42, 32'h0000_8000, "lhu 42");
    host_load_check(RD_W,  32'h40, 32'h8000_80F1, "lw 40");
    report_test("load_sizes", errs);
  endtask

  task automatic test_byte_mask();
    int unsigned errs;
    errs = err_cnt;
    track_store(SZ_WORD, 32'h48, 32'h1122_3344);
    track_store(SZ_WORD, 32'h4C, 32'h5566_7788);
    track_store(SZ_BYTE, 32'h49, 32'hDEAD_BEA7);  // upper bits must not land
    track_store(SZ_BYTE, 32'h4E, 32'h0000_0019);
    track_store(SZ_HALF, 32'h4C, 32'hCAFE_F00D);
    host_load_check(RD_W, 32'h48,
      {ref_bytes[3], ref_bytes[2], ref_bytes[1], ref_bytes[0]}, "lw 48");
    host_load_check(RD_W, 32'h4C,
      {ref_bytes[7], ref_bytes[6], ref_bytes[5], ref_bytes[4]}, "lw 4c");
    report_test("byte_mask", errs);
  endtask

  task automatic test_uart_out();
    int unsigned errs;
    int unsigned t0;
    logic [7:0]  b0;
    logic [7:0]  b1;
    errs = err_cnt;
    fork
      begin
        host_store(SZ_BYTE, UART_OUT_ADDR, 32'h5C);
        t0 = cycle_cnt;
        host_store(SZ_BYTE, UART_OUT_ADDR, 32'h3A);  // stalls behind frame 1
        check_value("uart out stall", 32'(cycle_cnt - t0 >= 8 * CPB), 32'd1);
      end
      begin
        uart_receive(b0);
        uart_receive(b1);
      end
    join
    check_value("uart_tx byte 0", 32'(b0), 32'h5C);
    check_value("uart_tx byte 1", 32'(b1), 32'h3A);
    report_test("uart_out", errs);
  endtask

  task automatic test_uart_in();
    int unsigned errs;
    errs = err_cnt;
    uart_send(8'hC3);
    host_load_check(RD_UB, UART_IN_ADDR, 32'h0000_00C3, "uart in");
    host_load_check(RD_UB, UART_IN_ADDR, 32'h0000_0000, "uart in empty");
    report_test("uart_in", errs);
  endtask

  task automatic test_leds();
    int unsigned errs;
    errs = err_cnt;
    host_store(SZ_BYTE, LED_ADDR, 32'h0A);
    check_value("led[4:1]", 32'(led[4:1]), 32'hA);
    check_value("led[5]", 32'(led[5]), 32'd1);  // host idle
    check_value("led[0]", 32'(led[0]), 32'd1);
    report_test("leds", errs);
  endtask

  // --------------------------------------------------------------------------
  // run
  // --------------------------------------------------------------------------

  initial begin
    host_req = '0;
    uart_rx  = 1'b1;  // line idle
    do @(posedge clk); while (rst !== 1'b0);
    test_boot_copy();
    test_load_sizes();
    test_byte_mask();
    test_uart_out();
    test_uart_in();
    test_leds();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, fail_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/soc_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/ramio.sv
hdl/flash_boot.sv
hdl/soc_top.sv
sim/tb_clk.sv
sim/tb_models.sv
sim/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_memio

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/soc_pkg.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/ramio.sv
      - hdl/flash_boot.sv
      - hdl/soc_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tb_clk.sv
      - sim/tb_models.sv
      - sim/tb_soc.sv
